// File: design/dataMemory.sv
`timescale 1ns/10ps

module dataMemory (
    input  logic            clk,
    input  logic            reqValid,
    input  lsuPkg::memReqT  req,
    output logic            respValid,
    output lsuPkg::laneIdxT respLane,
    output logic [31:0]     respData
);
    import lsuPkg::*;

    logic [31:0]             mem [MemWords];
    logic [WordIdxWidth-1:0] wordIdx;

    assign wordIdx = req.addr[WordIdxWidth+1:2];

    // Byte-masked write
    always_ff @(posedge clk) begin
        if (reqValid && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strb[b]) begin
                    mem[wordIdx][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    // Reads answer one cycle later, tagged with the lane
    always_ff @(posedge clk) begin
        respValid <= reqValid && !req.write;
        respLane <= req.lane;
        respData <= mem[wordIdx];
    end

endmodule

// File: design/loadStoreLane.sv
`timescale 1ns/10ps

module loadStoreLane #(
    parameter lsuPkg::laneIdxT LaneIdx = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          load,
    input  lsuPkg::uopOp                  op,
    input  logic [lsuPkg::RobIdWidth-1:0] robId,
    input  logic [lsuPkg::RegWidth-1:0]   dst,
    input  logic [31:0]                   base,
    input  logic [31:0]                   storeData,
    input  logic [15:0]                   offset,
    output logic                          idle,
    input  logic                          fireValid,
    input  logic [lsuPkg::RobIdWidth-1:0] fireRobId,
    output logic                          reqValid,
    input  logic                          reqReady,
    output lsuPkg::memReqT                req,
    input  logic                          respValid,
    input  lsuPkg::laneIdxT               respLane,
    input  logic [31:0]                   respData,
    output logic                          cmtValid,
    input  logic                          cmtReady,
    output lsuPkg::commitT                cmt
);
    import lsuPkg::*;

    typedef enum logic [2:0] {
        sIdle,
        sLoadReq,
        sLoadResp,
        sLoadCommit,
        sStoreCommit,
        sStoreWait,
        sStoreFire,
        sRecover
    } laneState;

    laneState state;
    laneState nextState;

    uopOp                  opReg;
    logic [RobIdWidth-1:0] robIdReg;
    logic [RegWidth-1:0]   dstReg;
    logic [31:0]           addrReg;
    logic [31:0]           storeDataReg;
    logic [31:0]           loadResult;
    logic                  fired;

    logic        respHit;
    logic        fireHitIn;
    logic        fireHitReg;
    logic [7:0]  respByte;
    logic [15:0] respHalf;
    logic [31:0] extended;
    logic [31:0] wrData;
    logic [3:0]  wrStrb;

    assign respHit = respValid && (respLane == LaneIdx);
    assign fireHitIn = fireValid && (fireRobId == robId);
    assign fireHitReg = fireValid && (fireRobId == robIdReg);

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            sIdle: begin
                if (load && !flush) begin
                    nextState = (op inside {SB, SH, SW}) ? sStoreCommit : sLoadReq;
                end
            end
            sLoadReq: begin
                // Accepted this cycle means a response is already on its way
                if (reqReady) begin
                    nextState = flush ? sRecover : sLoadResp;
                end else if (flush) begin
                    nextState = sIdle;
                end
            end
            sLoadResp: begin
                if (respHit) begin
                    nextState = flush ? sIdle : sLoadCommit;
                end else if (flush) begin
                    nextState = sRecover;
                end
            end
            sLoadCommit: begin
                if (flush || cmtReady) begin
                    nextState = sIdle;
                end
            end
            sStoreCommit: begin
                if (flush) begin
                    nextState = sIdle;
                end else if (cmtReady) begin
                    nextState = (fired || fireHitReg) ? sStoreFire : sStoreWait;
                end
            end
            sStoreWait: begin
                if (flush) begin
                    nextState = sIdle;
                end else if (fireHitReg) begin
                    nextState = sStoreFire;
                end
            end
            sStoreFire: begin
                if (flush || reqReady) begin
                    nextState = sIdle;
                end
            end
            sRecover: begin
                if (respHit) begin
                    nextState = sIdle;
                end
            end
            default: nextState = sIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
            fired <= 1'b0;
        end else begin
            state <= nextState;
            if (state == sIdle && load) begin
                fired <= fireHitIn;
            end else if (state == sStoreCommit && fireHitReg) begin
                fired <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == sIdle && load) begin
            opReg <= op;
            robIdReg <= robId;
            dstReg <= dst;
            addrReg <= base + {{16{offset[15]}}, offset};
            storeDataReg <= storeData;
        end
        if (state == sLoadResp && respHit) begin
            loadResult <= extended;
        end
    end

    //////////////////////////////
    // Load extension
    //////////////////////////////

    assign respByte = 8'(respData >> {addrReg[1:0], 3'b000});
    assign respHalf = addrReg[1] ? respData[31:16] : respData[15:0];

    always_comb begin
        case (opReg)
            LB:      extended = {{24{respByte[7]}}, respByte};
            LBU:     extended = {24'b0, respByte};
            LH:      extended = {{16{respHalf[15]}}, respHalf};
            LHU:     extended = {16'b0, respHalf};
            default: extended = respData;
        endcase
    end

    // Store data moved into its byte lanes
    always_comb begin
        case (opReg)
            SB: begin
                wrData = {24'b0, storeDataReg[7:0]} << {addrReg[1:0], 3'b000};
                wrStrb = 4'b0001 << addrReg[1:0];
            end
            SH: begin
                wrData = addrReg[1] ? {storeDataReg[15:0], 16'b0} : {16'b0, storeDataReg[15:0]};
                wrStrb = addrReg[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wrData = storeDataReg;
                wrStrb = 4'b1111;
            end
        endcase
    end

    assign idle = (state == sIdle);

    assign reqValid = (state == sLoadReq) || (state == sStoreFire);
    assign req.lane = LaneIdx;
    assign req.write = (state == sStoreFire);
    assign req.addr = {addrReg[31:2], 2'b00};
    assign req.data = wrData;
    assign req.strb = wrStrb;

    assign cmtValid = (state == sLoadCommit) || (state == sStoreCommit);
    assign cmt.robId = robIdReg;
    assign cmt.dst = dstReg;
    assign cmt.wen = (state == sLoadCommit);
    assign cmt.data = (state == sLoadCommit) ? loadResult : 32'b0;

endmodule

// File: design/lsuPkg.sv
package lsuPkg;

    //////////////////////////////
    // Cluster sizing
    //////////////////////////////

    localparam int LaneCount = 4;
    localparam int RobIdWidth = 6;
    localparam int RegWidth = 6;

    // Byte addressed, one word per entry
    localparam int MemWords = 256;
    localparam int WordIdxWidth = $clog2(MemWords);

    // Wide enough to count every lane
    localparam int BusyWidth = $clog2(LaneCount + 1);

    //////////////////////////////
    // Micro-op encoding
    //////////////////////////////

    typedef enum logic [2:0] {
        LB,
        LH,
        LBU,
        LHU,
        LW,
        SB,
        SH,
        SW
    } uopOp;

    typedef logic [1:0] laneIdxT;

    //////////////////////////////
    // Arbiter payloads
    //////////////////////////////

    // Lane tag comes back with the read response
    typedef struct packed {
        laneIdxT     lane;
        logic        write;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } memReqT;

    // wen low marks a store
    typedef struct packed {
        logic [RobIdWidth-1:0] robId;
        logic [RegWidth-1:0]   dst;
        logic                  wen;
        logic [31:0]           data;
    } commitT;

endpackage

// File: design/lsuSubsystem.sv
`timescale 1ns/10ps

module lsuSubsystem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          inValid,
    output logic                          inReady,
    input  lsuPkg::uopOp                  inOp,
    input  logic [lsuPkg::RobIdWidth-1:0] inRobId,
    input  logic [lsuPkg::RegWidth-1:0]   inDst,
    input  logic [31:0]                   inBase,
    input  logic [31:0]                   inStoreData,
    input  logic [15:0]                   inOffset,
    input  logic                          fireValid,
    input  logic [lsuPkg::RobIdWidth-1:0] fireRobId,
    output logic                          commitValid,
    input  logic                          commitReady,
    output logic [lsuPkg::RobIdWidth-1:0] commitRobId,
    output logic [lsuPkg::RegWidth-1:0]   commitDst,
    output logic                          commitWen,
    output logic [31:0]                   commitData,
    output logic [lsuPkg::BusyWidth-1:0]  busyLanes
);
    import lsuPkg::*;

    logic                  laneIdle [LaneCount];
    logic                  laneLoad [LaneCount];
    uopOp                  laneOp;
    logic [RobIdWidth-1:0] laneRobId;
    logic [RegWidth-1:0]   laneDst;
    logic [31:0]           laneBase;
    logic [31:0]           laneStoreData;
    logic [15:0]           laneOffset;

    logic   memReqValid [LaneCount];
    logic   memReqReady [LaneCount];
    memReqT memReq [LaneCount];
    logic   memValid;
    memReqT memSel;

    logic        respValid;
    laneIdxT     respLane;
    logic [31:0] respData;

    logic   cmtValid [LaneCount];
    logic   cmtReady [LaneCount];
    commitT cmt [LaneCount];
    commitT commitSel;

    uopDispatch u_uopDispatch (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .inValid       (inValid),
        .inReady       (inReady),
        .inOp          (inOp),
        .inRobId       (inRobId),
        .inDst         (inDst),
        .inBase        (inBase),
        .inStoreData   (inStoreData),
        .inOffset      (inOffset),
        .laneIdle      (laneIdle),
        .laneLoad      (laneLoad),
        .laneOp        (laneOp),
        .laneRobId     (laneRobId),
        .laneDst       (laneDst),
        .laneBase      (laneBase),
        .laneStoreData (laneStoreData),
        .laneOffset    (laneOffset)
    );

    //////////////////////////////
    // Lanes
    //////////////////////////////

    for (genvar g = 0; g < LaneCount; g++) begin : gLane
        loadStoreLane #(
            .LaneIdx (laneIdxT'(g))
        ) u_loadStoreLane (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .load      (laneLoad[g]),
            .op        (laneOp),
            .robId     (laneRobId),
            .dst       (laneDst),
            .base      (laneBase),
            .storeData (laneStoreData),
            .offset    (laneOffset),
            .idle      (laneIdle[g]),
            .fireValid (fireValid),
            .fireRobId (fireRobId),
            .reqValid  (memReqValid[g]),
            .reqReady  (memReqReady[g]),
            .req       (memReq[g]),
            .respValid (respValid),
            .respLane  (respLane),
            .respData  (respData),
            .cmtValid  (cmtValid[g]),
            .cmtReady  (cmtReady[g]),
            .cmt       (cmt[g])
        );
    end

    //////////////////////////////
    // Memory side
    //////////////////////////////

    // Memory never stalls
    streamArbiter #(
        .payloadT (memReqT),
        .Ports    (LaneCount)
    ) u_memArbiter (
        .clk      (clk),
        .rst      (rst),
        .inValid  (memReqValid),
        .inReady  (memReqReady),
        .inData   (memReq),
        .outValid (memValid),
        .outReady (1'b1),
        .outData  (memSel)
    );

    dataMemory u_dataMemory (
        .clk       (clk),
        .reqValid  (memValid),
        .req       (memSel),
        .respValid (respValid),
        .respLane  (respLane),
        .respData  (respData)
    );

    streamArbiter #(
        .payloadT (commitT),
        .Ports    (LaneCount)
    ) u_commitArbiter (
        .clk      (clk),
        .rst      (rst),
        .inValid  (cmtValid),
        .inReady  (cmtReady),
        .inData   (cmt),
        .outValid (commitValid),
        .outReady (commitReady),
        .outData  (commitSel)
    );

    assign commitRobId = commitSel.robId;
    assign commitDst = commitSel.dst;
    assign commitWen = commitSel.wen;
    assign commitData = commitSel.data;

    always_comb begin
        busyLanes = '0;
        for (int i = 0; i < LaneCount; i++) begin
            busyLanes = busyLanes + BusyWidth'(!laneIdle[i]);
        end
    end

endmodule

// File: design/streamArbiter.sv
`timescale 1ns/10ps

module streamArbiter #(
    parameter type payloadT = logic [31:0],
    parameter int  Ports = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid [Ports],
    output logic    inReady [Ports],
    input  payloadT inData [Ports],
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic [$clog2(Ports)-1:0] ptr;
    logic [$clog2(Ports)-1:0] grantIdx;
    logic [$clog2(Ports)-1:0] lockIdx;
    logic                     locked;
    logic                     found;

    // A stalled winner keeps the grant so its payload holds
    always_comb begin
        int cand;
        cand = 0;
        found = 1'b0;
        grantIdx = '0;
        if (locked && inValid[lockIdx]) begin
            found = 1'b1;
            grantIdx = lockIdx;
        end else begin
            for (int k = 0; k < Ports; k++) begin
                cand = (int'(ptr) + k) % Ports;
                if (!found && inValid[cand]) begin
                    found = 1'b1;
                    grantIdx = cand[$clog2(Ports)-1:0];
                end
            end
        end
    end

    assign outValid = found;
    assign outData = inData[grantIdx];

    always_comb begin
        for (int i = 0; i < Ports; i++) begin
            inReady[i] = outReady && found && (int'(grantIdx) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
            locked <= 1'b0;
        end else begin
            locked <= found && !outReady;
            // Rotate past the port just served
            if (found && outReady) begin
                ptr <= (int'(grantIdx) == Ports - 1) ? '0 : grantIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        lockIdx <= grantIdx;
    end

endmodule

// File: design/uopDispatch.sv
`timescale 1ns/10ps

module uopDispatch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          inValid,
    output logic                          inReady,
    input  lsuPkg::uopOp                  inOp,
    input  logic [lsuPkg::RobIdWidth-1:0] inRobId,
    input  logic [lsuPkg::RegWidth-1:0]   inDst,
    input  logic [31:0]                   inBase,
    input  logic [31:0]                   inStoreData,
    input  logic [15:0]                   inOffset,
    input  logic                          laneIdle [lsuPkg::LaneCount],
    output logic                          laneLoad [lsuPkg::LaneCount],
    output lsuPkg::uopOp                  laneOp,
    output logic [lsuPkg::RobIdWidth-1:0] laneRobId,
    output logic [lsuPkg::RegWidth-1:0]   laneDst,
    output logic [31:0]                   laneBase,
    output logic [31:0]                   laneStoreData,
    output logic [15:0]                   laneOffset
);
    import lsuPkg::*;

    logic    anyFree;
    laneIdxT pick;

    // Lowest idle lane wins; the lane loaded last cycle still reads idle
    always_comb begin
        anyFree = 1'b0;
        pick = '0;
        for (int i = LaneCount - 1; i >= 0; i--) begin
            if (laneIdle[i] && !laneLoad[i]) begin
                anyFree = 1'b1;
                pick = laneIdxT'(i);
            end
        end
    end

    assign inReady = anyFree && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LaneCount; i++) begin
                laneLoad[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < LaneCount; i++) begin
                laneLoad[i] <= inValid && inReady && (pick == laneIdxT'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            laneOp <= inOp;
            laneRobId <= inRobId;
            laneDst <= inDst;
            laneBase <= inBase;
            laneStoreData <= inStoreData;
            laneOffset <= inOffset;
        end
    end

endmodule

// File: files.f
design/lsuPkg.sv
design/uopDispatch.sv
design/loadStoreLane.sv
design/streamArbiter.sv
design/dataMemory.sv
design/lsuSubsystem.sv
testbench/lsuSubsystem_checker.sv
testbench/lsuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module lsuTb -f files.f -o lsuSim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/lsuSim); then
    echo "$output"
    echo "Simulation exited with an error"
    exit 1
fi

echo "$output"

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// File: testbench/lsuSubsystem_checker.sv
`timescale 1ns/10ps

module lsuSubsystem_checker (
    input logic                          clk,
    input logic                          rst,
    input logic                          flush,
    input logic                          commitValid,
    input logic                          commitReady,
    input logic [lsuPkg::RobIdWidth-1:0] commitRobId,
    input logic [lsuPkg::RegWidth-1:0]   commitDst,
    input logic                          commitWen,
    input logic [31:0]                   commitData,
    input logic [lsuPkg::BusyWidth-1:0]  busyLanes
);
    import lsuPkg::*;

    // Stalled commit holds valid and payload unless a flush drops it
    commitStable: assert property (@(posedge clk) disable iff (rst)
        commitValid && !commitReady && !flush |=> commitValid
            && $stable({commitRobId, commitDst, commitWen, commitData}))
        else $error("commit changed while stalled");

    // First edge only clears the state, so look one edge later
    noCommitInReset: assert property (@(posedge clk)
        rst && $past(rst) |-> !commitValid)
        else $error("commit valid during reset");

    busyInRange: assert property (@(posedge clk) disable iff (rst)
        busyLanes <= BusyWidth'(LaneCount))
        else $error("busy lane count out of range");

endmodule

// File: testbench/lsuTb.sv
`timescale 1ns/10ps

module lsuTb;
    import lsuPkg::*;

    localparam int SlotCount = 64;
    localparam int RandStores = 48;
    localparam int ExtSlots = 16;
    localparam int BpOps = 48;
    localparam int TotalUops = 2 * SlotCount + RandStores + 4 * ExtSlots + BpOps + 6 + 12;
    localparam int CycleLimit = TotalUops * 40;

    logic clk;
    logic rst;
    logic flush;
    logic inValid;
    logic inReady;
    uopOp inOp;
    logic [RobIdWidth-1:0] inRobId;
    logic [RegWidth-1:0] inDst;
    logic [31:0] inBase;
    logic [31:0] inStoreData;
    logic [15:0] inOffset;
    logic fireValid;
    logic [RobIdWidth-1:0] fireRobId;
    logic commitValid;
    logic commitReady;
    logic [RobIdWidth-1:0] commitRobId;
    logic [RegWidth-1:0] commitDst;
    logic commitWen;
    logic [31:0] commitData;
    logic [BusyWidth-1:0] busyLanes;

    // Model state
    logic [7:0] modelMem [SlotCount*4];
    bit pending [1 << RobIdWidth];
    logic [RegWidth-1:0] expDst [1 << RobIdWidth];
    logic expWen [1 << RobIdWidth];
    logic [31:0] expData [1 << RobIdWidth];
    int pendingCount;
    logic [RobIdWidth-1:0] nextRob;
    logic [RobIdWidth-1:0] lastRob;

    logic [31:0] lfsr;
    int errors;
    int checks;
    int startErrors;
    int cycles;
    string testName;
    int readyMode;
    bit sawFull;

    lsuSubsystem u_lsuSubsystem (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .inValid     (inValid),
        .inReady     (inReady),
        .inOp        (inOp),
        .inRobId     (inRobId),
        .inDst       (inDst),
        .inBase      (inBase),
        .inStoreData (inStoreData),
        .inOffset    (inOffset),
        .fireValid   (fireValid),
        .fireRobId   (fireRobId),
        .commitValid (commitValid),
        .commitReady (commitReady),
        .commitRobId (commitRobId),
        .commitDst   (commitDst),
        .commitWen   (commitWen),
        .commitData  (commitData),
        .busyLanes   (busyLanes)
    );

    bind lsuSubsystem lsuSubsystem_checker u_lsuSubsystemChecker (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .commitValid (commitValid),
        .commitReady (commitReady),
        .commitRobId (commitRobId),
        .commitDst   (commitDst),
        .commitWen   (commitWen),
        .commitData  (commitData),
        .busyLanes   (busyLanes)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("ERROR @%0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // Little-endian read of the model with MIPS extension rules
    function automatic logic [31:0] loadValue(input uopOp op, input int addr);
        logic [7:0] b;
        logic [15:0] h;
        int w;
        b = modelMem[addr];
        h = {modelMem[(addr & ~1) + 1], modelMem[addr & ~1]};
        w = addr & ~3;
        case (op)
            LB: return {{24{b[7]}}, b};
            LBU: return {24'b0, b};
            LH: return {{16{h[15]}}, h};
            LHU: return {16'b0, h};
            default: return {modelMem[w+3], modelMem[w+2], modelMem[w+1], modelMem[w]};
        endcase
    endfunction

    task automatic applyStore(input uopOp op, input int addr, input logic [31:0] data);
        if (op == SB) begin
            modelMem[addr] = data[7:0];
        end else if (op == SH) begin
            modelMem[addr & ~1] = data[7:0];
            modelMem[(addr & ~1) + 1] = data[15:8];
        end else begin
            for (int b = 0; b < 4; b++) begin
                modelMem[(addr & ~3) + b] = data[8*b +: 8];
            end
        end
    endtask

    task automatic issueUop(input uopOp op, input int addr, input logic [31:0] data);
        logic [15:0] off;
        logic [RegWidth-1:0] dst;
        logic [RobIdWidth-1:0] rob;
        logic ok;
        off = 16'(randBits(16));
        dst = RegWidth'(randBits(RegWidth));
        rob = nextRob;
        nextRob = nextRob + 1'b1;
        if (pending[rob]) begin
            $display("Reorder id %0d reused while its commit is still outstanding", rob);
            errors++;
        end
        pending[rob] = 1'b1;
        pendingCount++;
        expDst[rob] = dst;
        expWen[rob] = !(op inside {SB, SH, SW});
        expData[rob] = expWen[rob] ? loadValue(op, addr) : 32'b0;
        inValid = 1'b1;
        inOp = op;
        inRobId = rob;
        inDst = dst;
        inBase = 32'(addr) - {{16{off[15]}}, off};
        inStoreData = data;
        inOffset = off;
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = inReady;
            @(posedge clk);
            #1;
        end
        inValid = 1'b0;
        lastRob = rob;
    endtask

    task automatic fireStore(input logic [RobIdWidth-1:0] rob, input uopOp op,
                             input int addr, input logic [31:0] data);
        fireValid = 1'b1;
        fireRobId = rob;
        applyStore(op, addr, data);
        @(posedge clk);
        #1;
        fireValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (pendingCount != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitIdle();
        while (busyLanes != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic storeInOrder(input uopOp op, input int addr, input logic [31:0] data);
        logic [RobIdWidth-1:0] rob;
        issueUop(op, addr, data);
        rob = lastRob;
        waitDrain();
        fireStore(rob, op, addr, data);
        waitIdle();
    endtask

    task automatic beginTest(input string name);
        testName = name;
        startErrors = errors;
    endtask

    task automatic endTest();
        $display("%s: %s (%0d mismatches)", testName,
                 (errors == startErrors) ? "pass" : "fail", errors - startErrors);
    endtask

    //////////////////////////////
    // Commit monitor and stall driver
    //////////////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (commitValid && commitReady) begin
                    if (!pending[commitRobId]) begin
                        $display("Unexpected commit for reorder id %0d at %0t", commitRobId, $time);
                        errors++;
                    end else begin
                        checkEq(32'(commitWen), 32'(expWen[commitRobId]), "commit wen");
                        checkEq(32'(commitDst), 32'(expDst[commitRobId]), "commit dst");
                        checkEq(commitData, expData[commitRobId], "commit data");
                        pending[commitRobId] = 1'b0;
                        pendingCount--;
                    end
                end
                if (busyLanes == BusyWidth'(LaneCount)) begin
                    sawFull = 1'b1;
                    if (inReady) begin
                        $display("inReady high while every lane is busy at %0t", $time);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        int stretch;
        logic lowNow;
        stretch = 0;
        lowNow = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (readyMode == 1) begin
                if (stretch == 0) begin
                    lowNow = randBits(1);
                    stretch = int'(randBits(3));
                end else begin
                    stretch--;
                end
                commitReady = !lowNow;
            end else begin
                commitReady = (readyMode == 0);
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CycleLimit) begin
                $display("Timeout: test %s did not finish within %0d cycles", testName, CycleLimit);
                $display("Errors found");
                $finish;
            end
        end
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    initial begin
        uopOp op;
        int slot;
        int addr;
        int sel;
        logic [31:0] d;
        logic [31:0] dA;
        logic [31:0] dB;
        logic [RobIdWidth-1:0] robA;
        logic [RobIdWidth-1:0] robB;
        lfsr = 32'd39;
        errors = 0;
        checks = 0;
        pendingCount = 0;
        nextRob = '0;
        lastRob = '0;
        readyMode = 0;
        sawFull = 1'b0;
        testName = "reset";
        rst = 1'b1;
        flush = 1'b0;
        inValid = 1'b0;
        inOp = LB;
        inRobId = '0;
        inDst = '0;
        inBase = '0;
        inStoreData = '0;
        inOffset = '0;
        fireValid = 1'b0;
        fireRobId = '0;
        commitReady = 1'b1;
        for (int i = 0; i < (1 << RobIdWidth); i++) begin
            pending[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        beginTest("store then load");
        for (int s = 0; s < SlotCount; s++) begin
            storeInOrder(SW, s * 4, randBits(32));
        end
        for (int i = 0; i < RandStores; i++) begin
            sel = int'(randBits(2));
            slot = int'(randBits(6));
            d = randBits(32);
            if (sel == 0) begin
                storeInOrder(SB, slot * 4 + int'(randBits(2)), d);
            end else if (sel == 1) begin
                storeInOrder(SH, slot * 4 + 2 * int'(randBits(1)), d);
            end else begin
                storeInOrder(SW, slot * 4, d);
            end
        end
        repeat (10) @(posedge clk);
        #1;
        for (int s = 0; s < SlotCount; s++) begin
            issueUop(LW, s * 4, '0);
        end
        waitDrain();
        endTest();

        beginTest("load extension");
        for (int s = 0; s < ExtSlots; s++) begin
            for (int b = 0; b < 4; b++) begin
                sel = int'(randBits(2));
                op = (sel == 0) ? LB : (sel == 1) ? LBU : (sel == 2) ? LH : LHU;
                addr = (op inside {LH, LHU}) ? s * 4 + (b & 2) : s * 4 + b;
                issueUop(op, addr, '0);
            end
        end
        waitDrain();
        endTest();

        // Loads only, so no store ordering is involved
        beginTest("back-pressure");
        readyMode = 1;
        sawFull = 1'b0;
        for (int i = 0; i < BpOps; i++) begin
            sel = int'(randBits(3));
            op = (sel > 4) ? LW : uopOp'(sel);
            slot = int'(randBits(6));
            addr = (op == LW) ? slot * 4 : (op inside {LH, LHU}) ? slot * 4 + 2 * int'(randBits(1))
                : slot * 4 + int'(randBits(2));
            issueUop(op, addr, '0);
        end
        waitDrain();
        readyMode = 0;
        if (!sawFull) begin
            $display("All lanes were never busy at once during back-pressure");
            errors++;
        end
        endTest();

        beginTest("store fire gating");
        slot = int'(randBits(6));
        dA = randBits(32);
        dB = randBits(32);
        issueUop(SW, slot * 4, dA);
        robA = lastRob;
        issueUop(SW, ((slot + 1) % SlotCount) * 4, dB);
        robB = lastRob;
        waitDrain();
        issueUop(LW, slot * 4, '0);
        issueUop(LW, ((slot + 1) % SlotCount) * 4, '0);
        waitDrain();
        fireStore(robA, SW, slot * 4, dA);
        fireStore(robB, SW, ((slot + 1) % SlotCount) * 4, dB);
        waitIdle();
        issueUop(LW, slot * 4, '0);
        issueUop(LW, ((slot + 1) % SlotCount) * 4, '0);
        waitDrain();
        endTest();

        beginTest("flush");
        readyMode = 2;
        @(posedge clk);
        #1;
        robA = nextRob;
        for (int i = 0; i < LaneCount; i++) begin
            issueUop(LW, int'(randBits(6)) * 4, '0);
        end
        flush = 1'b1;
        // Flushed loads must never commit
        for (int i = 0; i < LaneCount; i++) begin
            pending[robA + RobIdWidth'(i)] = 1'b0;
        end
        pendingCount = 0;
        @(posedge clk);
        #1;
        flush = 1'b0;
        readyMode = 0;
        for (int i = 0; i < 8; i++) begin
            issueUop(LW, int'(randBits(6)) * 4, '0);
        end
        // Each lane is idle on the edge that takes its last commit
        waitDrain();
        checkEq(32'(busyLanes), 32'd0, "busy lanes after flush");
        endTest();

        $display("Checks: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
